// File: hdl/aluPkg.sv
// Execution unit definitions
// Arithmetic sign mode and operation class shared by the decoder
// and the multiply and divide sequencers

package aluPkg;

    // Sign interpretation of a and b
    // SIGNED_UNSIGNED treats a as signed and b as unsigned
    typedef enum logic [1:0] {
        UNSIGNED        = 2'd0,
        SIGNED          = 2'd1,
        SIGNED_UNSIGNED = 2'd2
    } signModeT;

    // Which datapath produces the result
    typedef enum logic [2:0] {
        SIMPLE   = 3'd0,
        MULTIPLY = 3'd1,
        DIVIDE   = 3'd2,
        MODULO   = 3'd3,
        INVALID  = 3'd4
    } opClassT;

endpackage

// File: hdl/aluTop.sv
// ALU top level
// Four-phase req/ack front end that holds the request operands and
// the response around the execution unit

`timescale 1ns/1ps
`include "alu_config.svh"

module aluTop import isaPkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              req,
    input  instrT             instr,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    input  logic [`XLEN-1:0]  c,
    output logic              ack,
    output logic [`XLEN-1:0]  result,
    output logic              divByZero
);

    logic             busy;
    logic             startQ;
    logic             launch;
    instrT            instrQ;
    logic [`XLEN-1:0] aQ;
    logic [`XLEN-1:0] bQ;
    logic [`XLEN-1:0] cQ;
    logic             exDone;
    logic [`XLEN-1:0] exResult;
    logic             exDbz;

    // Accept only when idle and the previous ack has dropped
    assign launch = req && !busy && !ack;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            busy      <= 1'b0;
            startQ    <= 1'b0;
            ack       <= 1'b0;
            result    <= '0;
            divByZero <= 1'b0;
        end
        else
        begin
            startQ <= launch;
            if (launch)
                busy <= 1'b1;
            else if (busy && exDone)
            begin
                busy      <= 1'b0;
                ack       <= 1'b1;
                result    <= exResult;
                divByZero <= exDbz;
            end
            else if (ack && !req)
                ack <= 1'b0;
        end
    end

    // Operand holding registers
    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            instrQ <= instr;
            aQ     <= a;
            bQ     <= b;
            cQ     <= c;
        end
    end

    execUnit uExec (
        .clk(clk), .rstN(rstN), .start(startQ), .instr(instrQ),
        .a(aQ), .b(bQ), .c(cQ),
        .done(exDone), .result(exResult), .divByZero(exDbz)
    );

    assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> $past(req))
        else $error("aluTop: ack raised without req");

    assert property (@(posedge clk) disable iff (!rstN)
                     busy && $past(busy) |-> $stable({instrQ, aQ, bQ, cQ}))
        else $error("aluTop: held operands changed while busy");

endmodule

// File: hdl/alu_config.svh
// ALU configuration
// Data path width, immediate field width and the result pattern
// returned for an undefined operation

`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Data word width
`define XLEN 64

// Immediate field of the instruction word
`define IMM_WIDTH 16

// Returned for undefined opcode or function code
`define UNDEF_RESULT {(`XLEN/16){16'hDEAD}}

`endif

// File: hdl/execUnit.sv
// Integer execution unit
// Decodes the instruction, computes single-cycle operations directly
// and runs multiply, divide and modulo on the sequencers

`timescale 1ns/1ps
`include "alu_config.svh"

module execUnit import isaPkg::*, aluPkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    input  instrT             instr,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    input  logic [`XLEN-1:0]  c,
    output logic              done,
    output logic [`XLEN-1:0]  result,
    output logic              divByZero
);

    localparam int ShW = $clog2(`XLEN);

    functT            fn;
    logic             legalOp;
    logic             useImm;
    opClassT          opClass;
    signModeT         signMode;
    logic [`XLEN-1:0] immExt;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] simpleResult;
    logic [`XLEN-1:0] product;
    logic [`XLEN-1:0] quotient;
    logic [`XLEN-1:0] remainder;
    logic             mulStart;
    logic             divStart;
    logic             mulDone;
    logic             divDone;
    logic             divDbz;

    // ======================================================================
    // Decode
    // ======================================================================
    // Immediate opcodes map onto the matching register function
    always_comb
    begin
        fn      = instr.rr.funct;
        legalOp = 1'b1;
        useImm  = 1'b1;
        case (instr.rr.opcode)
            RR:      useImm = 1'b0;
            ADDI:    fn = ADD;
            CMPI:    fn = CMP;
            CMPUI:   fn = CMPU;
            ANDI:    fn = AND;
            ORI:     fn = OR;
            XORI:    fn = XOR;
            MULUI:   fn = MULU;
            MULSUI:  fn = MULSU;
            MULI:    fn = MUL;
            DIVUI:   fn = DIVU;
            DIVSUI:  fn = DIVSU;
            DIVI:    fn = DIV;
            MODUI:   fn = MODU;
            MODSUI:  fn = MODSU;
            MODI:    fn = MOD;
            default: legalOp = 1'b0;
        endcase
    end

    always_comb
    begin
        signMode = UNSIGNED;
        case (fn)
            ADD, SUB, CMP, CMPU, AND, OR, XOR, NAND, NOR, XNOR,
            SHL, SHR, ASR, CMOVEQ, CMOVNE, MUX:
                opClass = SIMPLE;
            MULU, MULSU, MUL:
                opClass = MULTIPLY;
            DIVU, DIVSU, DIV:
                opClass = DIVIDE;
            MODU, MODSU, MOD:
                opClass = MODULO;
            default:
                opClass = INVALID;
        endcase
        if (!legalOp)
            opClass = INVALID;
        if (fn == MUL || fn == DIV || fn == MOD)
            signMode = SIGNED;
        else if (fn == MULSU || fn == DIVSU || fn == MODSU)
            signMode = SIGNED_UNSIGNED;
    end

    assign immExt = {{(`XLEN-`IMM_WIDTH){instr.im.imm[`IMM_WIDTH-1]}}, instr.im.imm};
    assign opB    = useImm ? immExt : b;

    // ======================================================================
    // Single-cycle operations
    // ======================================================================
    always_comb
    begin
        case (fn)
            ADD:     simpleResult = a + opB;
            SUB:     simpleResult = a - opB;
            CMP:     simpleResult = ($signed(a) < $signed(opB)) ? '1 :
                                    (a == opB) ? '0 : {{(`XLEN-1){1'b0}}, 1'b1};
            CMPU:    simpleResult = (a < opB) ? '1 :
                                    (a == opB) ? '0 : {{(`XLEN-1){1'b0}}, 1'b1};
            AND:     simpleResult = a & opB;
            OR:      simpleResult = a | opB;
            XOR:     simpleResult = a ^ opB;
            NAND:    simpleResult = ~(a & opB);
            NOR:     simpleResult = ~(a | opB);
            XNOR:    simpleResult = ~(a ^ opB);
            SHL:     simpleResult = a << opB[ShW-1:0];
            SHR:     simpleResult = a >> opB[ShW-1:0];
            ASR:     simpleResult = $signed(a) >>> opB[ShW-1:0];
            CMOVEQ:  simpleResult = (a == '0) ? opB : c;
            CMOVNE:  simpleResult = (a != '0) ? opB : c;
            // Bit from b where a is set, else from c
            MUX:     simpleResult = (a & opB) | (~a & c);
            default: simpleResult = `UNDEF_RESULT;
        endcase
    end

    // ======================================================================
    // Sequencers and completion
    // ======================================================================
    assign mulStart = start && (opClass == MULTIPLY);
    assign divStart = start && (opClass == DIVIDE || opClass == MODULO);

    seqMultiplier uMul (
        .clk(clk), .rstN(rstN), .start(mulStart), .signMode(signMode),
        .a(a), .b(opB), .done(mulDone), .product(product)
    );

    seqDivider uDiv (
        .clk(clk), .rstN(rstN), .start(divStart), .signMode(signMode),
        .a(a), .b(opB), .done(divDone), .quotient(quotient),
        .remainder(remainder), .divByZero(divDbz)
    );

    always_comb
    begin
        divByZero = 1'b0;
        case (opClass)
            SIMPLE:   begin done = start;   result = simpleResult; end
            MULTIPLY: begin done = mulDone; result = product; end
            DIVIDE:   begin done = divDone; result = quotient;  divByZero = divDbz; end
            MODULO:   begin done = divDone; result = remainder; divByZero = divDbz; end
            default:  begin done = start;   result = `UNDEF_RESULT; end
        endcase
    end

endmodule

// File: hdl/isaPkg.sv
// Instruction set definitions
// Opcode and function code encodings and the two instruction formats

`include "alu_config.svh"

package isaPkg;

    // ======================================================================
    // Major opcode, bits 31..26
    // ======================================================================
    typedef enum logic [5:0] {
        RR     = 6'h02,
        ADDI   = 6'h04,
        CMPI   = 6'h06,
        CMPUI  = 6'h07,
        ANDI   = 6'h08,
        ORI    = 6'h09,
        XORI   = 6'h0A,
        MULUI  = 6'h38,
        MULSUI = 6'h39,
        MULI   = 6'h3A,
        DIVUI  = 6'h3C,
        DIVSUI = 6'h3D,
        DIVI   = 6'h3E,
        MODUI  = 6'h2C,
        MODSUI = 6'h2D,
        MODI   = 6'h2E
    } opcodeT;

    // ======================================================================
    // Function code of register-register words, bits 5..0
    // ======================================================================
    typedef enum logic [5:0] {
        ADD    = 6'h04,
        SUB    = 6'h05,
        CMP    = 6'h06,
        CMPU   = 6'h07,
        AND    = 6'h08,
        OR     = 6'h09,
        XOR    = 6'h0A,
        NAND   = 6'h0C,
        NOR    = 6'h0D,
        XNOR   = 6'h0E,
        SHL    = 6'h10,
        SHR    = 6'h11,
        ASR    = 6'h13,
        CMOVEQ = 6'h28,
        CMOVNE = 6'h29,
        MUX    = 6'h2A,
        MULU   = 6'h38,
        MULSU  = 6'h39,
        MUL    = 6'h3A,
        DIVU   = 6'h3C,
        DIVSU  = 6'h3D,
        DIV    = 6'h3E,
        MODU   = 6'h2C,
        MODSU  = 6'h2D,
        MOD    = 6'h2E
    } functT;

    // Register-register format
    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        logic [4:0]  spare;
        functT       funct;
    } rrFormatT;

    // Immediate format, imm replaces operand b
    typedef struct packed {
        opcodeT                 opcode;
        logic [4:0]             ra;
        logic [4:0]             rb;
        logic [`IMM_WIDTH-1:0]  imm;
    } immFormatT;

    typedef union packed {
        rrFormatT   rr;
        immFormatT  im;
    } instrT;

endpackage

// File: hdl/seqDivider.sv
// Sequential divider
// Restoring division on operand magnitudes, one quotient bit per cycle.
// Quotient truncates toward zero, remainder follows the dividend sign

`timescale 1ns/1ps
`include "alu_config.svh"

module seqDivider import aluPkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    input  signModeT          signMode,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    output logic              done,
    output logic [`XLEN-1:0]  quotient,
    output logic [`XLEN-1:0]  remainder,
    output logic              divByZero
);

    localparam int CntW = $clog2(`XLEN);

    logic             busy;
    logic [CntW-1:0]  cnt;
    logic [`XLEN-1:0] rem;
    logic [`XLEN-1:0] quo;
    logic [`XLEN-1:0] dvsr;
    logic [`XLEN:0]   trial;
    logic             qNeg;
    logic             rNeg;
    logic             zeroDiv;
    logic             aNeg;
    logic             bNeg;

    always_comb
    begin
        aNeg = (signMode != UNSIGNED) && a[`XLEN-1];
        bNeg = (signMode == SIGNED) && b[`XLEN-1];
    end

    // ======================================================================
    // Control
    // ======================================================================
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy <= 1'b1;
                cnt  <= '0;
            end
            else if (busy)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == CntW'(`XLEN - 1))
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // ======================================================================
    // Datapath
    // ======================================================================
    // Partial remainder with the next dividend bit shifted in, less divisor
    assign trial = {rem, quo[`XLEN-1]} - {1'b0, dvsr};

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rem     <= '0;
            quo     <= aNeg ? -a : a;
            dvsr    <= bNeg ? -b : b;
            qNeg    <= aNeg ^ bNeg;
            rNeg    <= aNeg;
            zeroDiv <= (b == '0);
        end
        else if (busy)
        begin
            if (!trial[`XLEN])
            begin
                rem <= trial[`XLEN-1:0];
                quo <= {quo[`XLEN-2:0], 1'b1};
            end
            else
            begin
                rem <= {rem[`XLEN-2:0], quo[`XLEN-1]};
                quo <= {quo[`XLEN-2:0], 1'b0};
            end
        end
    end

    // A zero divisor leaves |a| in rem, so only the quotient is forced
    assign quotient  = zeroDiv ? '1 : (qNeg ? -quo : quo);
    assign remainder = rNeg ? -rem : rem;
    assign divByZero = zeroDiv;

    assert property (@(posedge clk) disable iff (!rstN) start |-> !busy)
        else $error("seqDivider: start while busy");

    assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
        else $error("seqDivider: done held longer than one cycle");

endmodule

// File: hdl/seqMultiplier.sv
// Sequential multiplier
// Radix-2 shift-and-add on operand magnitudes, one bit per cycle,
// giving the low word of the product

`timescale 1ns/1ps
`include "alu_config.svh"

module seqMultiplier import aluPkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    input  signModeT          signMode,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    output logic              done,
    output logic [`XLEN-1:0]  product
);

    localparam int CntW = $clog2(`XLEN);

    logic             busy;
    logic [CntW-1:0]  cnt;
    logic [`XLEN-1:0] acc;
    logic [`XLEN-1:0] mcand;
    logic [`XLEN-1:0] mplier;
    logic             negProd;
    logic             aNeg;
    logic             bNeg;

    always_comb
    begin
        aNeg = (signMode != UNSIGNED) && a[`XLEN-1];
        bNeg = (signMode == SIGNED) && b[`XLEN-1];
    end

    // Iteration counter, done pulses after the last add step
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy <= 1'b1;
                cnt  <= '0;
            end
            else if (busy)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == CntW'(`XLEN - 1))
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            acc     <= '0;
            mcand   <= aNeg ? -a : a;
            mplier  <= bNeg ? -b : b;
            negProd <= aNeg ^ bNeg;
        end
        else if (busy)
        begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Sign applied on the way out
    assign product = negProd ? -acc : acc;

    assert property (@(posedge clk) disable iff (!rstN) start |-> !busy)
        else $error("seqMultiplier: start while busy");

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the ALU testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module aluTb \
    -f src.f \
    -o aluSim

./obj_dir/aluSim

// File: src.f
+incdir+hdl
hdl/isaPkg.sv
hdl/aluPkg.sv
hdl/seqMultiplier.sv
hdl/seqDivider.sv
hdl/execUnit.sv
hdl/aluTop.sv
test/aluTb.sv

// File: test/aluTb.sv
// ALU testbench
// Random and corner-case operations through the req/ack port, checked
// against a reference model by concurrent assertions

`timescale 1ns/1ps
`include "alu_config.svh"

module aluTb import isaPkg::*;
();

    localparam int LongLatency    = `XLEN + 2;
    localparam int ShiftBits      = $clog2(`XLEN);
    localparam int WatchdogCycles = 8 + 200 * (`XLEN + 10);

    logic             clk;
    logic             rstN;
    logic             req;
    instrT            instrIn;
    logic [`XLEN-1:0] aIn;
    logic [`XLEN-1:0] bIn;
    logic [`XLEN-1:0] cIn;
    logic             ack;
    logic [`XLEN-1:0] result;
    logic             divByZero;

    logic [31:0]      lfsrState;
    logic [`XLEN-1:0] expResult;
    logic             expDbz;
    int               expLatency;
    int               waitCycles;
    int               opCount;

    aluTop dut (
        .clk(clk), .rstN(rstN), .req(req), .instr(instrIn),
        .a(aIn), .b(bIn), .c(cIn),
        .ack(ack), .result(result), .divByZero(divByZero)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // ======================================================================
    // Random data and instruction words
    // ======================================================================
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [`XLEN-1:0] randBits(input int n);
        logic [`XLEN-1:0] v;
        int               i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[`XLEN-2:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [`IMM_WIDTH-1:0] randImm();
        logic [`XLEN-1:0] v;
        v = randBits(`IMM_WIDTH);
        return v[`IMM_WIDTH-1:0];
    endfunction

    // Random words mixed with the extreme values
    function automatic logic [`XLEN-1:0] pickOperand();
        logic [`XLEN-1:0] sel;
        logic [`XLEN-1:0] v;
        sel = randBits(3);
        case (sel[2:0])
            3'd0:    v = '0;
            3'd1:    v = {1'b1, {(`XLEN-1){1'b0}}};
            3'd2:    v = {1'b0, {(`XLEN-1){1'b1}}};
            3'd3:    v = '1;
            3'd4:    v = randBits(8);
            3'd5:    v = -randBits(8);
            default: v = randBits(`XLEN);
        endcase
        return v;
    endfunction

    // Register fields carry junk, the unit ignores them
    function automatic instrT rrWord(input functT fn);
        logic [`XLEN-1:0] junk;
        junk = randBits(20);
        return {RR, junk[19:0], fn};
    endfunction

    function automatic instrT immWord(input opcodeT op, input logic [`IMM_WIDTH-1:0] imm);
        logic [`XLEN-1:0] junk;
        junk = randBits(10);
        return {op, junk[9:0], imm};
    endfunction

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic void computeExpected(
        input  instrT            ins,
        input  logic [`XLEN-1:0] a,
        input  logic [`XLEN-1:0] b,
        input  logic [`XLEN-1:0] c,
        output logic [`XLEN-1:0] res,
        output logic             dbz,
        output int               lat
    );
        functT                     fn;
        logic                      isImm;
        logic                      legal;
        logic                      aSigned;
        logic                      bSigned;
        logic [`XLEN-1:0]          opB;
        logic [`XLEN-1:0]          one;
        logic signed [2*`XLEN-1:0] aW;
        logic signed [2*`XLEN-1:0] bW;
        logic signed [2*`XLEN-1:0] wide;
        fn    = ins.rr.funct;
        isImm = 1'b1;
        legal = 1'b1;
        dbz   = 1'b0;
        lat   = 1;
        one   = {{(`XLEN-1){1'b0}}, 1'b1};
        case (ins.rr.opcode)
            RR:      isImm = 1'b0;
            ADDI:    fn = ADD;
            CMPI:    fn = CMP;
            CMPUI:   fn = CMPU;
            ANDI:    fn = AND;
            ORI:     fn = OR;
            XORI:    fn = XOR;
            MULUI:   fn = MULU;
            MULSUI:  fn = MULSU;
            MULI:    fn = MUL;
            DIVUI:   fn = DIVU;
            DIVSUI:  fn = DIVSU;
            DIVI:    fn = DIV;
            MODUI:   fn = MODU;
            MODSUI:  fn = MODSU;
            MODI:    fn = MOD;
            default: legal = 1'b0;
        endcase
        opB = isImm ? {{(`XLEN-`IMM_WIDTH){ins.im.imm[`IMM_WIDTH-1]}}, ins.im.imm} : b;
        // Exact wide operands so native division truncates toward zero
        aSigned = fn inside {MUL, MULSU, DIV, DIVSU, MOD, MODSU};
        bSigned = fn inside {MUL, DIV, MOD};
        aW = aSigned ? {{`XLEN{a[`XLEN-1]}}, a} : {{`XLEN{1'b0}}, a};
        bW = bSigned ? {{`XLEN{opB[`XLEN-1]}}, opB} : {{`XLEN{1'b0}}, opB};
        res = `UNDEF_RESULT;
        if (legal)
        begin
            case (fn)
                ADD:    res = a + opB;
                SUB:    res = a - opB;
                CMP:    res = ($signed(a) < $signed(opB)) ? '1 : ((a == opB) ? '0 : one);
                CMPU:   res = (a < opB) ? '1 : ((a == opB) ? '0 : one);
                AND:    res = a & opB;
                OR:     res = a | opB;
                XOR:    res = a ^ opB;
                NAND:   res = ~(a & opB);
                NOR:    res = ~(a | opB);
                XNOR:   res = ~(a ^ opB);
                SHL:    res = a << opB[ShiftBits-1:0];
                SHR:    res = a >> opB[ShiftBits-1:0];
                ASR:    res = $signed(a) >>> opB[ShiftBits-1:0];
                CMOVEQ: res = (a == '0) ? opB : c;
                CMOVNE: res = (a != '0) ? opB : c;
                MUX:    res = (opB & a) | (c & ~a);
                MULU, MULSU, MUL:
                begin
                    wide = aW * bW;
                    res  = wide[`XLEN-1:0];
                    lat  = LongLatency;
                end
                DIVU, DIVSU, DIV, MODU, MODSU, MOD:
                begin
                    lat = LongLatency;
                    if (opB == '0)
                    begin
                        dbz = 1'b1;
                        res = (fn inside {DIVU, DIVSU, DIV}) ? '1 : a;
                    end
                    else
                    begin
                        wide = (fn inside {DIVU, DIVSU, DIV}) ? aW / bW : aW % bW;
                        res  = wide[`XLEN-1:0];
                    end
                end
                default: res = `UNDEF_RESULT;
            endcase
        end
    endfunction

    // ======================================================================
    // Checks
    // ======================================================================
    // Edges with req high and ack low, the accepting edge included
    always_ff @(posedge clk)
    begin
        if (!rstN || !req)
            waitCycles <= 0;
        else if (req && !ack)
            waitCycles <= waitCycles + 1;
    end

    assert property (@(posedge clk) !rstN |=> !ack)
        else reportFailure($sformatf("error: ack is %h in reset, expected 0", ack));
    assert property (@(posedge clk) !rstN |=> result == '0)
        else reportFailure($sformatf("error: result is %h in reset, expected 0", result));
    assert property (@(posedge clk) $rose(ack) |-> $past(req))
        else reportFailure("ack rose while req was low");
    assert property (@(posedge clk) disable iff (!rstN) ack && !req |=> !ack)
        else reportFailure("ack stayed high a cycle after req fell");
    assert property (@(posedge clk) disable iff (!rstN) ack && req |=> $stable(result))
        else reportFailure($sformatf("error: result changed to %h under ack", result));
    assert property (@(posedge clk) disable iff (!rstN) ack && req |=> $stable(divByZero))
        else reportFailure($sformatf("error: divByZero changed to %h under ack", divByZero));
    assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> result == expResult)
        else reportFailure($sformatf("error: result is %h, expected %h", result, expResult));
    assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> divByZero == expDbz)
        else reportFailure($sformatf("error: divByZero is %h, expected %h", divByZero, expDbz));
    assert property (@(posedge clk) disable iff (!rstN)
                     $rose(ack) |-> waitCycles == expLatency + 1)
        else reportFailure($sformatf("error: ack latency is %h, expected %h",
                                     waitCycles - 1, expLatency));

    // ======================================================================
    // Stimulus
    // ======================================================================
    // One full four-phase transfer with a random hold of ack
    task automatic runOp(input instrT ins, input logic [`XLEN-1:0] a, b, c);
        logic [`XLEN-1:0] r;
        int               hold;
        computeExpected(ins, a, b, c, expResult, expDbz, expLatency);
        instrIn = ins;
        aIn     = a;
        bIn     = b;
        cIn     = c;
        req     = 1'b1;
        @(posedge clk);
        #1;
        while (!ack)
        begin
            @(posedge clk);
            #1;
        end
        // Inputs are free again once ack is up
        aIn  = randBits(`XLEN);
        bIn  = randBits(`XLEN);
        r    = randBits(2);
        hold = int'(r[1:0]);
        repeat (hold)
        begin
            @(posedge clk);
            #1;
        end
        req = 1'b0;
        while (ack)
        begin
            @(posedge clk);
            #1;
        end
        opCount++;
    endtask

    task automatic testSimple();
        functT            fns [16];
        opcodeT           ops [6];
        logic [`XLEN-1:0] a;
        int               i;
        int               k;
        fns = '{ADD, SUB, CMP, CMPU, AND, OR, XOR, NAND, NOR, XNOR,
                SHL, SHR, ASR, CMOVEQ, CMOVNE, MUX};
        ops = '{ADDI, CMPI, CMPUI, ANDI, ORI, XORI};
        for (i = 0; i < 16; i++)
        begin
            for (k = 0; k < 4; k++)
            begin
                a = pickOperand();
                runOp(rrWord(fns[i]), a, (k == 3) ? a : pickOperand(), pickOperand());
            end
        end
        for (i = 0; i < 6; i++)
            for (k = 0; k < 3; k++)
                runOp(immWord(ops[i], randImm()), pickOperand(), pickOperand(), '0);
    endtask

    task automatic testMultiply();
        functT  fns [3];
        opcodeT ops [3];
        int     i;
        int     k;
        fns = '{MULU, MULSU, MUL};
        ops = '{MULUI, MULSUI, MULI};
        for (i = 0; i < 3; i++)
        begin
            for (k = 0; k < 4; k++)
                runOp(rrWord(fns[i]), pickOperand(), pickOperand(), '0);
            for (k = 0; k < 2; k++)
                runOp(immWord(ops[i], randImm()), pickOperand(), '0, '0);
        end
    endtask

    // Both operand signs, extremes, then a zero divisor for every form
    task automatic testDivide();
        functT                 fns [6];
        opcodeT                ops [6];
        logic [`XLEN-1:0]      a;
        logic [`XLEN-1:0]      b;
        logic [`IMM_WIDTH-1:0] imm;
        int                    i;
        int                    k;
        fns = '{DIVU, DIVSU, DIV, MODU, MODSU, MOD};
        ops = '{DIVUI, DIVSUI, DIVI, MODUI, MODSUI, MODI};
        for (i = 0; i < 6; i++)
        begin
            for (k = 0; k < 6; k++)
            begin
                a = (k < 4) ? randBits(`XLEN) : pickOperand();
                b = (k < 4) ? randBits(16) : pickOperand();
                if (k < 4)
                begin
                    a[`XLEN-1] = k[0];
                    b[0] = 1'b1;
                    if (k[1])
                        b = -b;
                end
                if (b == '0)
                    b = '1;
                runOp(rrWord(fns[i]), a, b, '0);
            end
            for (k = 0; k < 2; k++)
            begin
                imm = randImm();
                imm[0] = 1'b1;
                runOp(immWord(ops[i], imm), pickOperand(), '0, '0);
            end
            runOp(rrWord(fns[i]), pickOperand(), '0, '0);
            runOp(immWord(ops[i], '0), pickOperand(), randBits(`XLEN), '0);
        end
    endtask

    task automatic testUndefined();
        instrT w;
        w = {6'h00, 26'h0};
        runOp(w, pickOperand(), pickOperand(), '0);
        w = {6'h3F, 26'h155};
        runOp(w, pickOperand(), pickOperand(), '0);
        w = {6'h05, 26'h3FFFFFF};
        runOp(w, pickOperand(), pickOperand(), '0);
        w = {RR, 20'h0, 6'h00};
        runOp(w, pickOperand(), pickOperand(), '0);
        w = {RR, 20'h0, 6'h3F};
        runOp(w, pickOperand(), pickOperand(), '0);
        w = {RR, 20'h0, 6'h15};
        runOp(w, pickOperand(), pickOperand(), '0);
    endtask

    initial
    begin
        lfsrState  = 32'hf8b677eb;
        rstN       = 1'b0;
        req        = 1'b0;
        instrIn    = '0;
        aIn        = '0;
        bIn        = '0;
        cIn        = '0;
        expResult  = '0;
        expDbz     = 1'b0;
        expLatency = 1;
        opCount    = 0;
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(posedge clk);
        #1;
        testSimple();
        testMultiply();
        testDivide();
        testUndefined();
        $display("TESTBENCH PASSED");
        $finish;
    end

    // Budget of 200 operations at the longest latency plus slack
    initial
    begin
        repeat (WatchdogCycles) @(posedge clk);
        reportFailure($sformatf("timeout: the DUT hung after %0d completed operations",
                                opCount));
    end

endmodule
